// File: slotSynth.f
hw/slotSynthPkg.sv
hw/slotRegisters.sv
hw/slotSequencer.sv
hw/waveAddressGen.sv
hw/envelopeGen.sv
hw/slotLevel.sv
hw/slotSynthTop.sv
tb/slotSynthChecker.sv
tb/slotSynthTb.sv

// File: Bender.yml
package:
  name: slotSynth

sources:
  - hw/slotSynthPkg.sv
  - hw/slotRegisters.sv
  - hw/slotSequencer.sv
  - hw/waveAddressGen.sv
  - hw/envelopeGen.sv
  - hw/slotLevel.sv
  - hw/slotSynthTop.sv
  - target: test
    files:
      - tb/slotSynthChecker.sv
      - tb/slotSynthTb.sv

// File: tb/slotSynthTb.sv
`default_nettype none

module slotSynthTb;

	logic CLK;
	logic RST_N;
	logic [5:0] hostAddr;
	logic [15:0] hostWrData;
	logic hostCs;
	logic [1:0] hostWe;
	logic hostRd;
	logic [15:0] RAM_Q;
	logic [3:0] testNum;
	wire [15:0] hostRdData;
	wire [15:0] RAM_A;
	wire ramRd;
	wire [15:0] sampleData;
	wire [2:0] sampleSlot;
	wire sampleValid;
	wire [31:0] checkCount;
	wire [31:0] errorCount;

	logic [15:0] waveMem [65536];
	int timeouts;
	logic [15:0] loopStart;

	// Reference model state
	logic [15:0] mRegs [8][8];
	logic [15:0] mAddr [8];
	slotSynthPkg::EnvState mState [8];
	int mVol [8];
	int mEnvVol;
	int mCycles;
	logic [7:0] mPendOn;
	logic [7:0] mPendOff;
	logic [7:0] keyBitsNow;
	logic mKeyExec;
	logic mTick;
	logic mKeyOn;
	logic mKeyOff;
	logic mRamRd;
	logic mReadPend;
	logic mWaveValid;
	logic [2:0] mTickSlot;
	logic [2:0] mSlotCount;
	logic [15:0] mRamA;
	logic [15:0] mWaveWord;
	logic [15:0] wrBits;
	int tl;
	int level;
	int product;

	logic expRamRd;
	logic [15:0] expRamA;
	logic expSampleValid;
	logic [15:0] expSampleData;
	logic [2:0] expSampleSlot;
	logic expRdValid;
	logic [15:0] expRdData;

	slotSynthTop DUT (
		.CLK(CLK), .RST_N(RST_N),
		.hostAddr(hostAddr), .hostWrData(hostWrData), .hostCs(hostCs),
		.hostWe(hostWe), .hostRd(hostRd), .hostRdData(hostRdData),
		.RAM_A(RAM_A), .ramRd(ramRd), .RAM_Q(RAM_Q),
		.sampleData(sampleData), .sampleSlot(sampleSlot), .sampleValid(sampleValid)
	);

	slotSynthChecker chk (
		.CLK(CLK), .testNum(testNum),
		.hostRdData(hostRdData), .RAM_A(RAM_A), .ramRd(ramRd),
		.sampleData(sampleData), .sampleSlot(sampleSlot), .sampleValid(sampleValid),
		.expRdValid(expRdValid), .expRdData(expRdData), .expRamRd(expRamRd),
		.expRamA(expRamA), .expSampleValid(expSampleValid),
		.expSampleData(expSampleData), .expSampleSlot(expSampleSlot),
		.checkCount(checkCount), .errorCount(errorCount)
	);

	always #50 CLK = ~CLK;

	// Wave memory answers one clock after a read
	always @(posedge CLK) begin
		if (ramRd) begin
			RAM_Q <= waveMem[RAM_A];
		end
	end

	function automatic logic [15:0] readableBits(input logic [2:0] idx);
		case (idx)
			3'd0: return 16'h0001;
			3'd4: return 16'h7FFF;
			3'd5: return 16'h03FF;
			3'd6, 3'd7: return 16'h00FF;
			default: return 16'hFFFF;
		endcase
	endfunction

	function automatic logic [15:0] advanceAddress(input logic [15:0] addr, input logic [2:0] s,
			input logic on);
		logic [15:0] loopEnd;
		loopEnd = mRegs[s][slotSynthPkg::RegLoopEnd];
		if (on) begin
			return mRegs[s][slotSynthPkg::RegStart];
		end
		if (addr >= loopEnd) begin
			return addr - (loopEnd - mRegs[s][slotSynthPkg::RegLoopStart]);
		end
		return addr + {8'h00, mRegs[s][slotSynthPkg::RegStep][7:0]};
	endfunction

	task automatic stepEnvelope(input logic [2:0] s, input logic on, input logic off);
		int ar;
		int d1r;
		int d2r;
		int rr;
		int dl;
		int vol;
		ar = mRegs[s][slotSynthPkg::RegRates] & 31;
		d1r = (mRegs[s][slotSynthPkg::RegRates] >> 5) & 31;
		d2r = (mRegs[s][slotSynthPkg::RegRates] >> 10) & 31;
		rr = mRegs[s][slotSynthPkg::RegRelease] & 31;
		dl = (mRegs[s][slotSynthPkg::RegRelease] >> 5) & 31;
		vol = mVol[s];
		if (on) begin
			mState[s] = slotSynthPkg::EnvAttack;
		end else if (off && mState[s] != slotSynthPkg::EnvIdle) begin
			mState[s] = slotSynthPkg::EnvRelease;
		end else begin
			case (mState[s])
				slotSynthPkg::EnvAttack: begin
					vol = vol + ar * 32 + 31;
					if (vol > 1023) begin
						vol = 1023;
						mState[s] = slotSynthPkg::EnvDecay1;
					end
				end
				slotSynthPkg::EnvDecay1: begin
					vol = vol - d1r * 32;
					if (vol <= dl * 32) begin
						vol = dl * 32;
						mState[s] = slotSynthPkg::EnvDecay2;
					end
				end
				slotSynthPkg::EnvDecay2: begin
					vol = (vol - d2r * 32 < 0) ? 0 : vol - d2r * 32;
				end
				slotSynthPkg::EnvRelease: begin
					vol = vol - rr * 32;
					if (vol <= 0) begin
						vol = 0;
						mState[s] = slotSynthPkg::EnvIdle;
					end
				end
				default: begin
					vol = mVol[s];
				end
			endcase
		end
		mVol[s] = vol;
		mEnvVol = vol;
	endtask

	// Cycle model with registered outputs aligned to the DUT ports
	always @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			for (int s = 0; s < 8; s++) begin
				for (int r = 0; r < 8; r++) begin
					mRegs[s][r] = '0;
				end
				mAddr[s] = '0;
				mState[s] = slotSynthPkg::EnvIdle;
				mVol[s] = 0;
			end
			mCycles = 0;
			mEnvVol = 0;
			mPendOn = '0;
			mPendOff = '0;
			{mKeyExec, mTick, mKeyOn, mKeyOff, mRamRd, mReadPend, mWaveValid} = '0;
			mTickSlot = '0;
			mSlotCount = '0;
			mRamA = '0;
			mWaveWord = '0;
			expRamRd <= 1'b0;
			expRamA <= '0;
			expSampleValid <= 1'b0;
			expSampleData <= '0;
			expSampleSlot <= '0;
			expRdValid <= 1'b0;
			expRdData <= '0;
		end else begin
			expSampleValid <= mWaveValid;
			if (mWaveValid) begin
				tl = mRegs[mTickSlot][slotSynthPkg::RegTotalLevel] & 16'h00FF;
				level = mEnvVol - 4 * tl;
				if (level < 0) begin
					level = 0;
				end
				product = $signed(mWaveWord) * level;
				expSampleData <= 16'(product >>> 10);
				expSampleSlot <= mTickSlot;
			end
			mWaveValid = mReadPend;
			if (mReadPend) begin
				mWaveWord = waveMem[mRamA];
			end
			mReadPend = mRamRd;
			mRamRd = mTick;
			if (mTick) begin
				mAddr[mTickSlot] = advanceAddress(mAddr[mTickSlot], mTickSlot, mKeyOn);
				mRamA = mAddr[mTickSlot];
				stepEnvelope(mTickSlot, mKeyOn, mKeyOff);
			end
			expRamRd <= mRamRd;
			expRamA <= mRamA;
			for (int s = 0; s < 8; s++) begin
				keyBitsNow[s] = mRegs[s][slotSynthPkg::RegControl][0];
			end
			if (mCycles % slotSynthPkg::SlotCycles == slotSynthPkg::SlotCycles - 1) begin
				mTick = 1'b1;
				mTickSlot = mSlotCount;
				mSlotCount = mSlotCount + 1'b1;
				mKeyOn = mPendOn[mTickSlot];
				mKeyOff = mPendOff[mTickSlot];
				mPendOn[mTickSlot] = 1'b0;
				mPendOff[mTickSlot] = 1'b0;
			end else begin
				mTick = 1'b0;
				mKeyOn = 1'b0;
				mKeyOff = 1'b0;
			end
			// A fresh key request replaces what is pending
			if (mKeyExec) begin
				mPendOn = keyBitsNow;
				mPendOff = ~keyBitsNow;
			end
			mCycles++;
			mKeyExec = hostCs && hostWe[1] && hostAddr[2:0] == slotSynthPkg::RegControl
				&& hostWrData[15];
			wrBits = readableBits(hostAddr[2:0]);
			expRdValid <= hostCs && hostRd;
			if (hostCs && hostRd) begin
				expRdData <= mRegs[hostAddr[5:3]][hostAddr[2:0]] & wrBits;
			end
			if (hostCs && hostWe[0]) begin
				mRegs[hostAddr[5:3]][hostAddr[2:0]][7:0] = hostWrData[7:0] & wrBits[7:0];
			end
			if (hostCs && hostWe[1]) begin
				mRegs[hostAddr[5:3]][hostAddr[2:0]][15:8] = hostWrData[15:8] & wrBits[15:8];
			end
		end
	end

	function automatic logic [5:0] regAddress(input int s, input logic [2:0] idx);
		return {3'(s), idx};
	endfunction

	task automatic applyReset();
		@(negedge CLK);
		RST_N = 1'b0;
		repeat (8) @(negedge CLK);
		RST_N = 1'b1;
	endtask

	task automatic hostWrite(input logic [5:0] addr, input logic [15:0] data,
			input logic [1:0] we);
		@(negedge CLK);
		hostAddr = addr;
		hostWrData = data;
		hostWe = we;
		hostRd = 1'b0;
		hostCs = 1'b1;
		@(negedge CLK);
		hostCs = 1'b0;
		hostWe = 2'b00;
	endtask

	task automatic hostRead(input logic [5:0] addr);
		@(negedge CLK);
		hostAddr = addr;
		hostWe = 2'b00;
		hostRd = 1'b1;
		hostCs = 1'b1;
		@(negedge CLK);
		hostCs = 1'b0;
		hostRd = 1'b0;
	endtask

	// KB to every slot with execute on the slot 0 write
	task automatic keyAllSlots(input logic kb);
		for (int s = 1; s < 8; s++) begin
			hostWrite(regAddress(s, slotSynthPkg::RegControl), {15'h0000, kb}, 2'b01);
		end
		hostWrite(regAddress(0, slotSynthPkg::RegControl), {1'b1, 14'h0000, kb}, 2'b11);
	endtask

	task automatic finishRun();
		testNum = 4'd7;
		@(negedge CLK);
		@(negedge CLK);
		$display("checks %0d, mismatches %0d, timeouts %0d", checkCount, errorCount, timeouts);
		if (errorCount == 0 && timeouts == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	endtask

	task automatic abortRun(input string reason);
		timeouts++;
		$display("%s", reason);
		finishRun();
	endtask

	// Random host reads go out while the samples are awaited
	task automatic waitSamples(input int count);
		int waited;
		for (int n = 0; n < count; n++) begin
			waited = 0;
			do begin
				@(negedge CLK);
				hostCs = 1'b0;
				hostRd = 1'b0;
				if ($urandom_range(3) == 0) begin
					hostAddr = 6'($urandom());
					hostRd = 1'b1;
					hostCs = 1'b1;
				end
				waited++;
			end while (!sampleValid && waited < 3 * slotSynthPkg::SlotCycles);
			if (!sampleValid) begin
				abortRun("timed out waiting for sampleValid");
			end
		end
		hostCs = 1'b0;
		hostRd = 1'b0;
	endtask

	initial begin
		CLK = 1'b0;
		RST_N = 1'b1;
		hostAddr = '0;
		hostWrData = '0;
		hostCs = 1'b0;
		hostWe = 2'b00;
		hostRd = 1'b0;
		RAM_Q = '0;
		testNum = 4'd1;
		timeouts = 0;
		void'($urandom(88510));
		for (int a = 0; a < 65536; a++) begin
			waveMem[a] = 16'($urandom());
		end
		applyReset();

		for (int a = 0; a < 64; a++) begin
			hostWrite(6'(a), 16'($urandom()), 2'($urandom()));
		end
		for (int a = 0; a < 64; a++) begin
			hostRead(6'(a));
		end

		testNum = 4'd2;
		applyReset();
		waitSamples(1);

		testNum = 4'd3;
		waitSamples(3 * 8);

		testNum = 4'd4;
		for (int s = 0; s < 8; s++) begin
			loopStart = 16'($urandom_range(16'hEFFF));
			hostWrite(regAddress(s, slotSynthPkg::RegStart), 16'($urandom()), 2'b11);
			hostWrite(regAddress(s, slotSynthPkg::RegLoopStart), loopStart, 2'b11);
			hostWrite(regAddress(s, slotSynthPkg::RegLoopEnd),
				loopStart + 16'($urandom_range(1023, 1)), 2'b11);
			hostWrite(regAddress(s, slotSynthPkg::RegStep), 16'($urandom_range(255, 1)), 2'b11);
		end
		keyAllSlots(1'b1);
		waitSamples(8 * 30);

		testNum = 4'd5;
		for (int s = 0; s < 8; s++) begin
			hostWrite(regAddress(s, slotSynthPkg::RegRates), 16'($urandom()), 2'b11);
			hostWrite(regAddress(s, slotSynthPkg::RegRelease),
				{6'd0, 5'($urandom()), 5'($urandom_range(31, 1))}, 2'b11);
			hostWrite(regAddress(s, slotSynthPkg::RegTotalLevel), 16'($urandom_range(63)), 2'b11);
		end
		keyAllSlots(1'b1);
		waitSamples(8 * 60);

		testNum = 4'd6;
		keyAllSlots(1'b0);
		waitSamples(8 * 40);

		finishRun();
	end

endmodule

`default_nettype wire

// File: tb/slotSynthChecker.sv
`default_nettype none

module slotSynthChecker (
	input  wire         CLK,
	input  wire  [3:0]  testNum,
	input  wire  [15:0] hostRdData,
	input  wire  [15:0] RAM_A,
	input  wire         ramRd,
	input  wire  [15:0] sampleData,
	input  wire  [2:0]  sampleSlot,
	input  wire         sampleValid,
	input  wire         expRdValid,
	input  wire  [15:0] expRdData,
	input  wire         expRamRd,
	input  wire  [15:0] expRamA,
	input  wire         expSampleValid,
	input  wire  [15:0] expSampleData,
	input  wire  [2:0]  expSampleSlot,
	output int          checkCount,
	output int          errorCount
);

	string testNames [8];
	int lastTest;
	int testChecks;
	int testErrors;

	initial begin
		testNames[1] = "register readback";
		testNames[2] = "reset state";
		testNames[3] = "slot order and latency";
		testNames[4] = "address and loop sequence";
		testNames[5] = "envelope and level";
		testNames[6] = "key-off release";
		checkCount = 0;
		errorCount = 0;
		lastTest = 0;
		testChecks = 0;
		testErrors = 0;
	end

	task automatic compareValue(input string name, input logic [15:0] expected,
			input logic [15:0] actual);
		checkCount++;
		testChecks++;
		if (actual !== expected) begin
			errorCount++;
			testErrors++;
			$display("FAILED %s: expected 0x%04h, got 0x%04h at %0t", name, expected, actual,
				$time);
		end
	endtask

	// Values seen here are the ones settled before this edge
	always @(posedge CLK) begin
		if (testNum != lastTest) begin
			if (lastTest != 0) begin
				$display("test %0d %s: %0d checks, %0d mismatches", lastTest,
					testNames[lastTest], testChecks, testErrors);
			end
			lastTest = testNum;
			testChecks = 0;
			testErrors = 0;
		end
		compareValue("sampleValid", {15'd0, expSampleValid}, {15'd0, sampleValid});
		if (expSampleValid && sampleValid) begin
			compareValue("sampleSlot", {13'd0, expSampleSlot}, {13'd0, sampleSlot});
			compareValue("sampleData", expSampleData, sampleData);
		end
		compareValue("ramRd", {15'd0, expRamRd}, {15'd0, ramRd});
		if (expRamRd && ramRd) begin
			compareValue("RAM_A", expRamA, RAM_A);
		end
		if (expRdValid) begin
			compareValue("hostRdData", expRdData, hostRdData);
		end
	end

endmodule

`default_nettype wire

// File: hw/slotSynthTop.sv
`default_nettype none

module slotSynthTop (
	input  wire                                    CLK,
	input  wire                                    RST_N,
	input  wire  [slotSynthPkg::HostAddrBits-1:0]  hostAddr,
	input  wire  [slotSynthPkg::WordBits-1:0]      hostWrData,
	input  wire                                    hostCs,
	input  wire  [1:0]                             hostWe,
	input  wire                                    hostRd,
	output wire  [slotSynthPkg::WordBits-1:0]      hostRdData,
	output wire  [15:0]                            RAM_A,
	output wire                                    ramRd,
	input  wire  [slotSynthPkg::WordBits-1:0]      RAM_Q,
	output wire  [slotSynthPkg::WordBits-1:0]      sampleData,
	output wire  [slotSynthPkg::SlotBits-1:0]      sampleSlot,
	output wire                                    sampleValid
);

	wire                                  keyExec;
	wire [slotSynthPkg::NumSlots-1:0]     keyBits;
	wire                                  slotTick;
	wire [slotSynthPkg::SlotBits-1:0]     tickSlot;
	wire                                  keyOn;
	wire                                  keyOff;
	wire [slotSynthPkg::WordBits-1:0]     slotStart;
	wire [slotSynthPkg::WordBits-1:0]     slotLoopStart;
	wire [slotSynthPkg::WordBits-1:0]     slotLoopEnd;
	wire [slotSynthPkg::StepBits-1:0]     slotStep;
	wire [slotSynthPkg::RateBits-1:0]     slotAr;
	wire [slotSynthPkg::RateBits-1:0]     slotD1r;
	wire [slotSynthPkg::RateBits-1:0]     slotD2r;
	wire [slotSynthPkg::RateBits-1:0]     slotRr;
	wire [slotSynthPkg::RateBits-1:0]     slotDl;
	wire [slotSynthPkg::TlBits-1:0]       slotTl;
	wire [slotSynthPkg::WordBits-1:0]     waveWord;
	wire                                  waveValid;
	wire [slotSynthPkg::VolBits-1:0]      envVol;

	slotRegisters regs (
		.CLK(CLK), .RST_N(RST_N),
		.hostAddr(hostAddr), .hostWrData(hostWrData), .hostCs(hostCs),
		.hostWe(hostWe), .hostRd(hostRd), .tickSlot(tickSlot),
		.hostRdData(hostRdData), .keyExec(keyExec), .keyBits(keyBits),
		.slotStart(slotStart), .slotLoopStart(slotLoopStart), .slotLoopEnd(slotLoopEnd),
		.slotStep(slotStep), .slotAr(slotAr), .slotD1r(slotD1r), .slotD2r(slotD2r),
		.slotRr(slotRr), .slotDl(slotDl), .slotTl(slotTl)
	);

	slotSequencer seq (
		.CLK(CLK), .RST_N(RST_N),
		.keyExec(keyExec), .keyBits(keyBits),
		.slotTick(slotTick), .tickSlot(tickSlot), .keyOn(keyOn), .keyOff(keyOff)
	);

	// Address and envelope run side by side on the same tick
	waveAddressGen wave (
		.CLK(CLK), .RST_N(RST_N),
		.slotTick(slotTick), .tickSlot(tickSlot), .keyOn(keyOn),
		.slotStart(slotStart), .slotLoopStart(slotLoopStart), .slotLoopEnd(slotLoopEnd),
		.slotStep(slotStep), .RAM_Q(RAM_Q),
		.RAM_A(RAM_A), .ramRd(ramRd), .waveWord(waveWord), .waveValid(waveValid)
	);

	envelopeGen env (
		.CLK(CLK), .RST_N(RST_N),
		.slotTick(slotTick), .tickSlot(tickSlot), .keyOn(keyOn), .keyOff(keyOff),
		.slotAr(slotAr), .slotD1r(slotD1r), .slotD2r(slotD2r),
		.slotRr(slotRr), .slotDl(slotDl), .envVol(envVol)
	);

	slotLevel level (
		.CLK(CLK), .RST_N(RST_N),
		.waveValid(waveValid), .waveWord(waveWord), .envVol(envVol),
		.slotTl(slotTl), .tickSlot(tickSlot),
		.sampleData(sampleData), .sampleSlot(sampleSlot), .sampleValid(sampleValid)
	);

endmodule

`default_nettype wire

// File: hw/slotLevel.sv
`default_nettype none

module slotLevel (
	input  wire                                CLK,
	input  wire                                RST_N,
	input  wire                                waveValid,
	input  wire  [slotSynthPkg::WordBits-1:0]  waveWord,
	input  wire  [slotSynthPkg::VolBits-1:0]   envVol,
	input  wire  [slotSynthPkg::TlBits-1:0]    slotTl,
	input  wire  [slotSynthPkg::SlotBits-1:0]  tickSlot,
	output logic [slotSynthPkg::WordBits-1:0]  sampleData,
	output logic [slotSynthPkg::SlotBits-1:0]  sampleSlot,
	output logic                               sampleValid
);

	localparam int VB = slotSynthPkg::VolBits;
	localparam int WB = slotSynthPkg::WordBits;

	logic [VB-1:0] tlAtten;
	logic [VB:0] levelDiff;
	logic [VB-1:0] level;
	logic signed [WB+VB:0] product;

	// TL counts in steps of 4
	assign tlAtten = {slotTl, 2'b00};
	assign levelDiff = {1'b0, envVol} - {1'b0, tlAtten};
	assign level = levelDiff[VB] ? '0 : levelDiff[VB-1:0];

	assign product = $signed(waveWord) * $signed({1'b0, level});

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			sampleData <= '0;
			sampleSlot <= '0;
			sampleValid <= 1'b0;
		end else begin
			sampleValid <= waveValid;
			if (waveValid) begin
				// Arithmetic shift by 10, level below 1024 keeps it in 16 bits
				sampleData <= product[VB +: WB];
				sampleSlot <= tickSlot;
			end
		end
	end

endmodule

`default_nettype wire

// File: hw/envelopeGen.sv
`default_nettype none

module envelopeGen (
	input  wire                                CLK,
	input  wire                                RST_N,
	input  wire                                slotTick,
	input  wire  [slotSynthPkg::SlotBits-1:0]  tickSlot,
	input  wire                                keyOn,
	input  wire                                keyOff,
	input  wire  [slotSynthPkg::RateBits-1:0]  slotAr,
	input  wire  [slotSynthPkg::RateBits-1:0]  slotD1r,
	input  wire  [slotSynthPkg::RateBits-1:0]  slotD2r,
	input  wire  [slotSynthPkg::RateBits-1:0]  slotRr,
	input  wire  [slotSynthPkg::RateBits-1:0]  slotDl,
	output logic [slotSynthPkg::VolBits-1:0]   envVol
);

	localparam int VB = slotSynthPkg::VolBits;
	localparam int RS = slotSynthPkg::RateShift;

	slotSynthPkg::EnvState envState [slotSynthPkg::NumSlots];
	logic [VB-1:0] envLevel [slotSynthPkg::NumSlots];
	slotSynthPkg::EnvState curState;
	slotSynthPkg::EnvState nextState;
	logic [VB-1:0] curVol;
	logic [VB-1:0] nextVol;
	logic [VB-1:0] sustainVol;
	logic [slotSynthPkg::RateBits-1:0] subRate;
	logic [VB:0] attackSum;
	logic [VB:0] decayDiff;
	logic decayBorrow;

	assign curState = envState[tickSlot];
	assign curVol = envLevel[tickSlot];
	assign sustainVol = {slotDl, {RS{1'b0}}};

	// One subtractor shared by the falling phases
	always_comb begin
		case (curState)
			slotSynthPkg::EnvDecay1: subRate = slotD1r;
			slotSynthPkg::EnvDecay2: subRate = slotD2r;
			default: subRate = slotRr;
		endcase
	end

	assign attackSum = {1'b0, curVol} + {1'b0, slotAr, {RS{1'b1}}};
	assign decayDiff = {1'b0, curVol} - {1'b0, subRate, {RS{1'b0}}};
	assign decayBorrow = decayDiff[VB];

	always_comb begin
		nextState = curState;
		nextVol = curVol;
		if (keyOn) begin
			nextState = slotSynthPkg::EnvAttack;
		end else if (keyOff && curState != slotSynthPkg::EnvIdle) begin
			nextState = slotSynthPkg::EnvRelease;
		end else begin
			case (curState)
				slotSynthPkg::EnvAttack: begin
					if (attackSum > (VB + 1)'(slotSynthPkg::VolMax)) begin
						nextVol = VB'(slotSynthPkg::VolMax);
						nextState = slotSynthPkg::EnvDecay1;
					end else begin
						nextVol = attackSum[VB-1:0];
					end
				end
				slotSynthPkg::EnvDecay1: begin
					if (decayBorrow || decayDiff[VB-1:0] <= sustainVol) begin
						nextVol = sustainVol;
						nextState = slotSynthPkg::EnvDecay2;
					end else begin
						nextVol = decayDiff[VB-1:0];
					end
				end
				slotSynthPkg::EnvDecay2: begin
					nextVol = decayBorrow ? '0 : decayDiff[VB-1:0];
				end
				slotSynthPkg::EnvRelease: begin
					if (decayBorrow || decayDiff[VB-1:0] == '0) begin
						nextVol = '0;
						nextState = slotSynthPkg::EnvIdle;
					end else begin
						nextVol = decayDiff[VB-1:0];
					end
				end
				default: begin
					nextState = curState;
				end
			endcase
		end
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			for (int s = 0; s < slotSynthPkg::NumSlots; s++) begin
				envState[s] <= slotSynthPkg::EnvIdle;
				envLevel[s] <= '0;
			end
			envVol <= '0;
		end else if (slotTick) begin
			envState[tickSlot] <= nextState;
			envLevel[tickSlot] <= nextVol;
			envVol <= nextVol;
		end
	end

endmodule

`default_nettype wire

// File: hw/waveAddressGen.sv
`default_nettype none

module waveAddressGen (
	input  wire                                CLK,
	input  wire                                RST_N,
	input  wire                                slotTick,
	input  wire  [slotSynthPkg::SlotBits-1:0]  tickSlot,
	input  wire                                keyOn,
	input  wire  [slotSynthPkg::WordBits-1:0]  slotStart,
	input  wire  [slotSynthPkg::WordBits-1:0]  slotLoopStart,
	input  wire  [slotSynthPkg::WordBits-1:0]  slotLoopEnd,
	input  wire  [slotSynthPkg::StepBits-1:0]  slotStep,
	input  wire  [slotSynthPkg::WordBits-1:0]  RAM_Q,
	output logic [15:0]                        RAM_A,
	output logic                               ramRd,
	output logic [slotSynthPkg::WordBits-1:0]  waveWord,
	output logic                               waveValid
);

	logic [slotSynthPkg::WordBits-1:0] slotAddr [slotSynthPkg::NumSlots];
	logic [slotSynthPkg::WordBits-1:0] curAddr;
	logic [slotSynthPkg::WordBits-1:0] nextAddr;
	logic [slotSynthPkg::WordBits-1:0] loopLen;
	logic readPend;

	assign curAddr = slotAddr[tickSlot];
	assign loopLen = slotLoopEnd - slotLoopStart;

	always_comb begin
		if (keyOn) begin
			nextAddr = slotStart;
		end else if (curAddr >= slotLoopEnd) begin
			// Jump back by one loop length
			nextAddr = curAddr - loopLen;
		end else begin
			nextAddr = curAddr + slotSynthPkg::WordBits'(slotStep);
		end
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			for (int s = 0; s < slotSynthPkg::NumSlots; s++) begin
				slotAddr[s] <= '0;
			end
			RAM_A <= '0;
			ramRd <= 1'b0;
			readPend <= 1'b0;
			waveWord <= '0;
			waveValid <= 1'b0;
		end else begin
			ramRd <= slotTick;
			if (slotTick) begin
				slotAddr[tickSlot] <= nextAddr;
				RAM_A <= nextAddr;
			end
			// RAM answers one clock after the read strobe
			readPend <= ramRd;
			waveValid <= readPend;
			if (readPend) begin
				waveWord <= RAM_Q;
			end
		end
	end

endmodule

`default_nettype wire

// File: hw/slotSequencer.sv
`default_nettype none

module slotSequencer (
	input  wire                                CLK,
	input  wire                                RST_N,
	input  wire                                keyExec,
	input  wire  [slotSynthPkg::NumSlots-1:0]  keyBits,
	output logic                               slotTick,
	output logic [slotSynthPkg::SlotBits-1:0]  tickSlot,
	output logic                               keyOn,
	output logic                               keyOff
);

	localparam int TimerBits = $clog2(slotSynthPkg::SlotCycles);

	logic [TimerBits-1:0] cycleTimer;
	logic [slotSynthPkg::SlotBits-1:0] slotCount;
	logic [slotSynthPkg::NumSlots-1:0] pendOn;
	logic [slotSynthPkg::NumSlots-1:0] pendOff;
	logic lastCycle;

	assign lastCycle = (cycleTimer == TimerBits'(slotSynthPkg::SlotCycles - 1));

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			cycleTimer <= '0;
			slotCount <= '0;
			tickSlot <= '0;
			slotTick <= 1'b0;
			keyOn <= 1'b0;
			keyOff <= 1'b0;
			pendOn <= '0;
			pendOff <= '0;
		end else begin
			cycleTimer <= lastCycle ? '0 : cycleTimer + 1'b1;
			slotTick <= lastCycle;
			keyOn <= 1'b0;
			keyOff <= 1'b0;
			if (lastCycle) begin
				// tickSlot holds for the whole turn, the level stage reads it late
				tickSlot <= slotCount;
				slotCount <= slotCount + 1'b1;
				keyOn <= pendOn[slotCount];
				keyOff <= pendOff[slotCount];
				pendOn[slotCount] <= 1'b0;
				pendOff[slotCount] <= 1'b0;
			end
			// Newest request wins over one still pending
			if (keyExec) begin
				pendOn <= keyBits;
				pendOff <= ~keyBits;
			end
		end
	end

endmodule

`default_nettype wire

// File: hw/slotRegisters.sv
`default_nettype none

module slotRegisters (
	input  wire                                       CLK,
	input  wire                                       RST_N,
	input  wire  [slotSynthPkg::HostAddrBits-1:0]     hostAddr,
	input  wire  [slotSynthPkg::WordBits-1:0]         hostWrData,
	input  wire                                       hostCs,
	input  wire  [1:0]                                hostWe,
	input  wire                                       hostRd,
	input  wire  [slotSynthPkg::SlotBits-1:0]         tickSlot,
	output logic [slotSynthPkg::WordBits-1:0]         hostRdData,
	output logic                                      keyExec,
	output logic [slotSynthPkg::NumSlots-1:0]         keyBits,
	output logic [slotSynthPkg::WordBits-1:0]         slotStart,
	output logic [slotSynthPkg::WordBits-1:0]         slotLoopStart,
	output logic [slotSynthPkg::WordBits-1:0]         slotLoopEnd,
	output logic [slotSynthPkg::StepBits-1:0]         slotStep,
	output logic [slotSynthPkg::RateBits-1:0]         slotAr,
	output logic [slotSynthPkg::RateBits-1:0]         slotD1r,
	output logic [slotSynthPkg::RateBits-1:0]         slotD2r,
	output logic [slotSynthPkg::RateBits-1:0]         slotRr,
	output logic [slotSynthPkg::RateBits-1:0]         slotDl,
	output logic [slotSynthPkg::TlBits-1:0]           slotTl
);

	logic [slotSynthPkg::WordBits-1:0] regFile [slotSynthPkg::NumSlots][slotSynthPkg::NumRegs];
	logic [slotSynthPkg::SlotBits-1:0] hostSlot;
	slotSynthPkg::RegIndex hostReg;
	logic [slotSynthPkg::WordBits-1:0] wrMask;
	logic [slotSynthPkg::WordBits-1:0] ratesWord;
	logic [slotSynthPkg::WordBits-1:0] releaseWord;

	assign hostSlot = hostAddr[slotSynthPkg::HostAddrBits-1 -: slotSynthPkg::SlotBits];
	assign hostReg = slotSynthPkg::RegIndex'(
		hostAddr[slotSynthPkg::HostAddrBits-slotSynthPkg::SlotBits-1:0]);

	// Key-execute is a strobe, never stored
	always_comb begin
		wrMask = slotSynthPkg::RegMask[hostReg];
		if (hostReg == slotSynthPkg::RegControl) begin
			wrMask[slotSynthPkg::KeyExecBit] = 1'b0;
		end
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			for (int s = 0; s < slotSynthPkg::NumSlots; s++) begin
				for (int r = 0; r < slotSynthPkg::NumRegs; r++) begin
					regFile[s][r] <= '0;
				end
			end
			hostRdData <= '0;
			keyExec <= 1'b0;
		end else begin
			if (hostCs && hostWe[0]) begin
				regFile[hostSlot][hostReg][7:0] <= hostWrData[7:0] & wrMask[7:0];
			end
			if (hostCs && hostWe[1]) begin
				regFile[hostSlot][hostReg][15:8] <= hostWrData[15:8] & wrMask[15:8];
			end
			if (hostCs && hostRd) begin
				hostRdData <= regFile[hostSlot][hostReg] & slotSynthPkg::RegMask[hostReg];
			end
			keyExec <= hostCs && hostWe[1] && (hostReg == slotSynthPkg::RegControl)
				&& hostWrData[slotSynthPkg::KeyExecBit];
		end
	end

	always_comb begin
		for (int s = 0; s < slotSynthPkg::NumSlots; s++) begin
			keyBits[s] = regFile[s][slotSynthPkg::RegControl][slotSynthPkg::KeyBit];
		end
	end

	// Parameters of the slot being served
	assign ratesWord = regFile[tickSlot][slotSynthPkg::RegRates];
	assign releaseWord = regFile[tickSlot][slotSynthPkg::RegRelease];

	assign slotStart = regFile[tickSlot][slotSynthPkg::RegStart];
	assign slotLoopStart = regFile[tickSlot][slotSynthPkg::RegLoopStart];
	assign slotLoopEnd = regFile[tickSlot][slotSynthPkg::RegLoopEnd];
	assign slotStep = regFile[tickSlot][slotSynthPkg::RegStep][slotSynthPkg::StepBits-1:0];
	assign slotTl = regFile[tickSlot][slotSynthPkg::RegTotalLevel][slotSynthPkg::TlBits-1:0];
	assign slotAr = ratesWord[slotSynthPkg::ArLsb +: slotSynthPkg::RateBits];
	assign slotD1r = ratesWord[slotSynthPkg::D1rLsb +: slotSynthPkg::RateBits];
	assign slotD2r = ratesWord[slotSynthPkg::D2rLsb +: slotSynthPkg::RateBits];
	assign slotRr = releaseWord[slotSynthPkg::RrLsb +: slotSynthPkg::RateBits];
	assign slotDl = releaseWord[slotSynthPkg::DlLsb +: slotSynthPkg::RateBits];

endmodule

`default_nettype wire

// File: hw/slotSynthPkg.sv
`default_nettype none

package slotSynthPkg;

	// Slot schedule
	localparam int NumSlots = 8;
	localparam int SlotBits = 3;
	localparam int SlotCycles = 16;

	// Data widths
	localparam int WordBits = 16;
	localparam int VolBits = 10;
	localparam int VolMax = 1023;

	// Host word address is {slot, register index}
	localparam int HostAddrBits = 6;
	localparam int NumRegs = 8;

	// Register fields
	localparam int RateBits = 5;
	localparam int RateShift = 5;
	localparam int TlBits = 8;
	localparam int StepBits = 8;
	localparam int KeyBit = 0;
	localparam int KeyExecBit = 15;
	localparam int ArLsb = 0;
	localparam int D1rLsb = 5;
	localparam int D2rLsb = 10;
	localparam int RrLsb = 0;
	localparam int DlLsb = 5;

	typedef enum logic [2:0] {
		RegControl    = 3'd0,
		RegStart      = 3'd1,
		RegLoopStart  = 3'd2,
		RegLoopEnd    = 3'd3,
		RegRates      = 3'd4,
		RegRelease    = 3'd5,
		RegTotalLevel = 3'd6,
		RegStep       = 3'd7
	} RegIndex;

	// Implemented bits, indexed by RegIndex
	localparam logic [WordBits-1:0] RegMask [NumRegs] = '{
		16'h8001,
		16'hFFFF,
		16'hFFFF,
		16'hFFFF,
		16'h7FFF,
		16'h03FF,
		16'h00FF,
		16'h00FF
	};

	typedef enum logic [2:0] {
		EnvIdle    = 3'd0,
		EnvAttack  = 3'd1,
		EnvDecay1  = 3'd2,
		EnvDecay2  = 3'd3,
		EnvRelease = 3'd4
	} EnvState;

endpackage

`default_nettype wire
